// ==== logic/mul_taint_defines.svh ====
// Width settings for the taint-tracking shift-and-add multiplier
// Operand width may be overridden; the accumulator follows it
`ifndef MUL_TAINT_DEFINES_SVH
`define MUL_TAINT_DEFINES_SVH

// ==================================================
// Operand width
// ==================================================
`define MUL_WIDTH 8

// ==================================================
// Accumulator width
// ==================================================
// Two operand widths plus one bit to catch the add carry
`define MUL_SUM_WIDTH (2 * `MUL_WIDTH + 1)

`endif

// ==== logic/mul_taint_pkg.sv ====
// Shared types for the taint-tracking multiplier
// Every value field travels with a taint mask of equal width
`include "mul_taint_defines.svh"

package mul_taint_pkg;

    // Operand as presented at the top level
    typedef struct packed {
        logic [`MUL_WIDTH-1:0] value;
        logic [`MUL_WIDTH-1:0] taint;
    } opnd_t;

    // Accumulator-wide word, also used for the shifted multiplicand
    typedef struct packed {
        logic [`MUL_SUM_WIDTH-1:0] value;
        logic [`MUL_SUM_WIDTH-1:0] taint;
    } sum_word_t;

    // Step strobes from the controller, one taint bit covers all of them
    typedef struct packed {
        logic load;
        logic clear;
        logic add;
        logic shift;
        logic taint;
    } step_ctl_t;

endpackage

// ==== logic/mul_control.sv ====
// Sequencer for the shift-and-add multiplier
// Issues load, add and shift strobes and works out their control taint
`timescale 1ns/1ps
`include "mul_taint_defines.svh"

module mul_control
    import mul_taint_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      start,
    input  logic      start_t,
    input  logic      mplier_lsb,
    input  logic      mplier_lsb_t,
    output step_ctl_t ctl,
    output logic      busy,
    output logic      done
);

    localparam int CNT_W = $clog2(`MUL_WIDTH + 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_TEST,
        ST_ADD,
        ST_SHIFT,
        ST_FINISH
    } state_t;

    state_t           state_q;
    state_t           state_d;
    state_t           cur_state;
    logic [CNT_W-1:0] step_cnt;
    logic             step_count_done;
    logic             taint_q;
    logic             accept;

    // ==================================================
    // State decode
    // ==================================================
    // Test resolves within its own cycle into an add or a bare shift
    assign cur_state = (state_q == ST_TEST) ? (mplier_lsb ? ST_ADD : ST_SHIFT) : state_q;

    assign accept          = start && !busy;
    assign step_count_done = (step_cnt == CNT_W'(`MUL_WIDTH - 1));

    always_comb begin
        case (cur_state)
            ST_IDLE:   state_d = accept ? ST_LOAD : ST_IDLE;
            ST_FINISH: state_d = accept ? ST_LOAD : ST_IDLE;
            ST_LOAD:   state_d = ST_TEST;
            ST_ADD:    state_d = ST_SHIFT;
            ST_SHIFT:  state_d = step_count_done ? ST_FINISH : ST_TEST;
            default:   state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q  <= ST_IDLE;
            step_cnt <= '0;
            taint_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                taint_q <= start_t;
            end
            // Count shifts, one per multiplier bit
            if (cur_state == ST_LOAD) begin
                step_cnt <= '0;
            end else if (cur_state == ST_SHIFT) begin
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

    // ==================================================
    // Strobes and control taint
    // ==================================================
    assign ctl.load  = (cur_state == ST_LOAD);
    // Accumulator clear rides on the load strobe
    assign ctl.clear = 1'b0;
    assign ctl.add   = (cur_state == ST_ADD);
    assign ctl.shift = (cur_state == ST_SHIFT);

    // Add or skip hinges on the current multiplier bit, so its taint joins in
    always_comb begin
        if (ctl.load) begin
            ctl.taint = taint_q;
        end else if (ctl.add || ctl.shift) begin
            ctl.taint = taint_q | mplier_lsb_t;
        end else begin
            ctl.taint = 1'b0;
        end
    end

    assign busy = (state_q != ST_IDLE) && (state_q != ST_FINISH);
    assign done = (state_q == ST_FINISH);

endmodule

// ==== logic/multiplicand_reg.sv ====
// Multiplicand holding register
// Stores the operand shifted up by one operand width, with its taint
`timescale 1ns/1ps
`include "mul_taint_defines.svh"

module multiplicand_reg
    import mul_taint_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  step_ctl_t ctl,
    input  opnd_t     multiplicand,
    output sum_word_t mcand
);

    localparam int SW = `MUL_SUM_WIDTH;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mcand <= '0;
        end else if (ctl.load) begin
            mcand.value <= SW'(multiplicand.value) << `MUL_WIDTH;
            mcand.taint <= (SW'(multiplicand.taint) << `MUL_WIDTH) | {SW{ctl.taint}};
        end else begin
            // Held value still soaks up strobe taint
            mcand.taint <= mcand.taint | {SW{ctl.taint}};
        end
    end

endmodule

// ==== logic/multiplier_reg.sv ====
// Multiplier shift register
// Presents the current bit at bit 0 and shifts right on each step
`timescale 1ns/1ps
`include "mul_taint_defines.svh"

module multiplier_reg
    import mul_taint_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  step_ctl_t ctl,
    input  opnd_t     multiplier,
    output logic      mplier_lsb,
    output logic      mplier_lsb_t
);

    localparam int W = `MUL_WIDTH;

    logic [W-1:0] mplier_q;
    logic [W-1:0] mplier_t_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mplier_q   <= '0;
            mplier_t_q <= '0;
        end else if (ctl.load) begin
            mplier_q   <= multiplier.value;
            mplier_t_q <= multiplier.taint | {W{ctl.taint}};
        end else if (ctl.shift) begin
            // Zero enters at the top
            mplier_q   <= mplier_q >> 1;
            mplier_t_q <= (mplier_t_q >> 1) | {W{ctl.taint}};
        end else begin
            mplier_t_q <= mplier_t_q | {W{ctl.taint}};
        end
    end

    assign mplier_lsb   = mplier_q[0];
    assign mplier_lsb_t = mplier_t_q[0];

endmodule

// ==== logic/running_sum.sv ====
// Running-sum accumulator of the multiplier
// Clears, adds the multiplicand or shifts right, tracking taint through carries
`timescale 1ns/1ps
`include "mul_taint_defines.svh"

module running_sum
    import mul_taint_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  step_ctl_t ctl,
    input  sum_word_t mcand,
    output sum_word_t sum
);

    localparam int SW = `MUL_SUM_WIDTH;

    logic [SW-1:0] add_value;
    logic [SW-1:0] add_taint;

    // ==================================================
    // Carry taint
    // ==================================================
    // Marks bit i+1 when bit i produces a carry and one of its inputs is tainted
    function automatic logic [SW-1:0] carry_taint(
        input logic [SW-1:0] a,
        input logic [SW-1:0] a_t,
        input logic [SW-1:0] b,
        input logic [SW-1:0] b_t
    );
        logic [SW-1:0] t;
        logic          carry;
        logic          c_out;
        t     = '0;
        carry = 1'b0;
        for (int i = 0; i < SW - 1; i++) begin
            c_out = (a[i] & b[i]) | (a[i] & carry) | (b[i] & carry);
            if (c_out && (a_t[i] || b_t[i])) begin
                t[i + 1] = 1'b1;
            end
            carry = c_out;
        end
        return t;
    endfunction

    assign add_value = sum.value + mcand.value;
    assign add_taint = sum.taint | mcand.taint | {SW{ctl.taint}}
                     | carry_taint(sum.value, sum.taint, mcand.value, mcand.taint);

    // ==================================================
    // Accumulator register
    // ==================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sum <= '0;
        end else if (ctl.load || ctl.clear) begin
            sum.value <= '0;
            sum.taint <= {SW{ctl.taint}};
        end else if (ctl.add) begin
            sum.value <= add_value;
            sum.taint <= add_taint;
        end else if (ctl.shift) begin
            // Logical shift, the top bit fills with zero
            sum.value <= sum.value >> 1;
            sum.taint <= (sum.taint >> 1) | {SW{ctl.taint}};
        end
    end

endmodule

// ==== logic/mul_top.sv ====
// Top level of the taint-tracking sequential multiplier
// Joins the sequencer with the multiplicand, multiplier and accumulator blocks
`timescale 1ns/1ps
`include "mul_taint_defines.svh"

module mul_top
    import mul_taint_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    start,
    input  logic                    start_t,
    input  opnd_t                   multiplier,
    input  opnd_t                   multiplicand,
    output logic [2*`MUL_WIDTH-1:0] product,
    output logic [2*`MUL_WIDTH-1:0] product_t,
    output logic                    busy,
    output logic                    done
);

    step_ctl_t ctl;
    logic      mplier_lsb;
    logic      mplier_lsb_t;
    sum_word_t mcand;
    sum_word_t sum;

    // ==================================================
    // Sequencer
    // ==================================================
    mul_control u_control (
        .clk          (clk),
        .arst_n       (arst_n),
        .start        (start),
        .start_t      (start_t),
        .mplier_lsb   (mplier_lsb),
        .mplier_lsb_t (mplier_lsb_t),
        .ctl          (ctl),
        .busy         (busy),
        .done         (done)
    );

    // ==================================================
    // Datapath
    // ==================================================
    multiplicand_reg u_mcand (
        .clk          (clk),
        .arst_n       (arst_n),
        .ctl          (ctl),
        .multiplicand (multiplicand),
        .mcand        (mcand)
    );

    multiplier_reg u_mplier (
        .clk          (clk),
        .arst_n       (arst_n),
        .ctl          (ctl),
        .multiplier   (multiplier),
        .mplier_lsb   (mplier_lsb),
        .mplier_lsb_t (mplier_lsb_t)
    );

    running_sum u_sum (
        .clk          (clk),
        .arst_n       (arst_n),
        .ctl          (ctl),
        .mcand        (mcand),
        .sum          (sum)
    );

    // Carry bit is dropped, the product fits in the low half
    assign product   = sum.value[2*`MUL_WIDTH-1:0];
    assign product_t = sum.taint[2*`MUL_WIDTH-1:0];

endmodule

// ==== testbench/mul_top_sva.sv ====
// Protocol checks on the multiplier step strobes, busy and done
`timescale 1ns/1ps

module mul_top_sva
    import mul_taint_pkg::*;
(
    input logic      clk,
    input logic      arst_n,
    input step_ctl_t ctl,
    input logic      busy,
    input logic      done
);

    // At most one step strobe per cycle
    a_one_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({ctl.load, ctl.clear, ctl.add, ctl.shift}))
        else $error("More than one step strobe active");

    // Done is a single pulse and busy falls with it
    a_done_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        done |=> !done)
        else $error("Done held for more than one cycle");

    a_done_busy: assert property (@(posedge clk) disable iff (!arst_n)
        done |-> $fell(busy))
        else $error("Busy did not fall in the cycle of the done pulse");

    a_idle_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        !busy |-> !(ctl.load || ctl.clear || ctl.add || ctl.shift))
        else $error("Step strobe active while idle");

endmodule

bind mul_top mul_top_sva u_sva (
    .clk    (clk),
    .arst_n (arst_n),
    .ctl    (ctl),
    .busy   (busy),
    .done   (done)
);

// ==== testbench/mul_top_tb.sv ====
// Testbench for the taint-tracking shift-and-add multiplier
// LFSR-driven operands and taint, checked against a step-by-step model
`timescale 1ns/1ps
`include "mul_taint_defines.svh"

module mul_top_tb
    import mul_taint_pkg::*;
();

    localparam int W           = `MUL_WIDTH;
    localparam int SW          = `MUL_SUM_WIDTH;
    localparam int PW          = 2 * `MUL_WIDTH;
    localparam int N_PLAIN     = 200;
    localparam int N_OPND_T    = 120;
    localparam int N_START_T   = 30;
    localparam int NUM_TESTS   = N_PLAIN + N_OPND_T + N_START_T + W;
    localparam int CYCLE_LIMIT = NUM_TESTS * (2 * W + 4) + 200;

    logic          clk;
    logic          arst_n;
    logic          start;
    logic          start_t;
    opnd_t         multiplier;
    opnd_t         multiplicand;
    logic [PW-1:0] product;
    logic [PW-1:0] product_t;
    logic          busy;
    logic          done;

    logic [31:0] lfsr_state = 32'h96c59c19;
    int          value_errs = 0;
    int          taint_errs = 0;
    int          proto_errs = 0;
    int          done_count = 0;
    int          accepted   = 0;
    int          cycles     = 0;

    mul_top i_dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .start        (start),
        .start_t      (start_t),
        .multiplier   (multiplier),
        .multiplicand (multiplicand),
        .product      (product),
        .product_t    (product_t),
        .busy         (busy),
        .done         (done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Watchdog on total run length
    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, a done pulse never arrived", cycles);
        $display("Verification failed");
        $finish;
    end

    always @(negedge clk) begin
        if (done === 1'b1) begin
            done_count++;
        end
    end

    // ==================================================
    // Random bits and reference model
    // ==================================================
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits[i]    = lfsr_state[0];
        end
    endtask

    // One load, then per multiplier bit an optional add and a shift
    task automatic model_multiply(
        input  logic [W-1:0]  b,
        input  logic [W-1:0]  b_t,
        input  logic [W-1:0]  a,
        input  logic [W-1:0]  a_t,
        input  logic          st,
        output logic [PW-1:0] p,
        output logic [PW-1:0] p_t
    );
        logic [SW-1:0] a_v;
        logic [SW-1:0] at_v;
        logic [SW-1:0] s_v;
        logic [SW-1:0] s_t;
        logic [SW-1:0] c_t;
        logic [W-1:0]  m_v;
        logic [W-1:0]  m_t;
        logic [SW:0]   mask;
        logic [SW:0]   part;
        logic          c;
        a_v  = SW'(a) << W;
        at_v = (SW'(a_t) << W) | {SW{st}};
        m_v  = b;
        m_t  = b_t | {W{st}};
        s_v  = '0;
        s_t  = {SW{st}};
        for (int k = 0; k < W; k++) begin
            c = st | m_t[0];
            if (m_v[0]) begin
                // Carry out of bit i is bit i+1 of the partial sum of bits i..0
                c_t = '0;
                for (int i = 0; i < SW - 1; i++) begin
                    mask = ((SW + 1)'(1) << (i + 1)) - 1'b1;
                    part = ({1'b0, s_v} & mask) + ({1'b0, a_v} & mask);
                    if (part[i + 1] && (s_t[i] || at_v[i])) begin
                        c_t[i + 1] = 1'b1;
                    end
                end
                s_t  = s_t | at_v | {SW{c}} | c_t;
                s_v  = s_v + a_v;
                at_v = at_v | {SW{c}};
                m_t  = m_t | {W{c}};
            end
            s_v  = s_v >> 1;
            s_t  = (s_t >> 1) | {SW{c}};
            m_v  = m_v >> 1;
            m_t  = (m_t >> 1) | {W{c}};
            at_v = at_v | {SW{c}};
        end
        p   = s_v[PW-1:0];
        p_t = s_t[PW-1:0];
    endtask

    // ==================================================
    // One multiplication with an optional stray start
    // ==================================================
    task automatic run_one(
        input logic [W-1:0] b,
        input logic [W-1:0] b_t,
        input logic [W-1:0] a,
        input logic [W-1:0] a_t,
        input logic         st
    );
        logic [PW-1:0] exp_p;
        logic [PW-1:0] exp_t;
        logic [31:0]   r;
        model_multiply(b, b_t, a, a_t, st, exp_p, exp_t);
        draw_bits(1, r);
        if (r[0]) begin
            @(posedge clk);
        end
        @(posedge clk);
        assert (done_count == accepted)
            else begin
                proto_errs++;
                $display("Saw %0d done pulses for %0d accepted starts", done_count, accepted);
            end
        start        <= 1'b1;
        start_t      <= st;
        multiplier   <= '{value: b, taint: b_t};
        multiplicand <= '{value: a, taint: a_t};
        accepted++;
        @(posedge clk);
        start   <= 1'b0;
        start_t <= 1'b0;
        @(negedge clk);
        assert (busy === 1'b1)
            else begin
                proto_errs++;
                $display("Busy did not rise in the cycle after start at %0t", $time);
            end
        // Operands are already captured once the load cycle ends
        draw_bits(3, r);
        if (r[2]) begin
            repeat (r[1:0] + 1) @(posedge clk);
            draw_bits(32, r);
            start        <= 1'b1;
            start_t      <= 1'b1;
            multiplier   <= '{value: r[W-1:0], taint: r[2*W-1:W]};
            multiplicand <= '{value: r[3*W-1:2*W], taint: r[4*W-1:3*W]};
            @(posedge clk);
            start   <= 1'b0;
            start_t <= 1'b0;
        end
        @(negedge clk);
        while (done !== 1'b1) begin
            @(negedge clk);
        end
        assert (product === exp_p)
            else begin
                value_errs++;
                $display("ERR %0t product got %h expected %h", $time, product, exp_p);
            end
        assert (product_t === exp_t)
            else begin
                taint_errs++;
                $display("ERR %0t product_t got %h expected %h", $time, product_t, exp_t);
            end
    endtask

    initial begin
        logic [31:0]  r;
        logic [W-1:0] b;
        logic [W-1:0] a;
        arst_n       = 1'b0;
        start        = 1'b0;
        start_t      = 1'b0;
        multiplier   = '0;
        multiplicand = '0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        assert (busy === 1'b0 && done === 1'b0)
            else begin
                proto_errs++;
                $display("Busy or done is high right after reset");
            end

        // Untainted operands with the corners first
        for (int i = 0; i < N_PLAIN; i++) begin
            draw_bits(2 * W, r);
            b = (i < 4) ? {W{i[0]}} : r[W-1:0];
            a = (i < 4) ? {W{i[1]}} : r[2*W-1:W];
            run_one(b, '0, a, '0, 1'b0);
            assert (product === PW'(b) * PW'(a))
                else begin
                    value_errs++;
                    $display("ERR %0t product got %h expected %h", $time, product,
                             PW'(b) * PW'(a));
                end
            assert (product_t === '0)
                else begin
                    taint_errs++;
                    $display("ERR %0t product_t got %h expected 0", $time, product_t);
                end
        end

        // Sparse random operand taint
        for (int i = 0; i < N_OPND_T; i++) begin
            draw_bits(2 * W, r);
            b = r[W-1:0];
            a = r[2*W-1:W];
            draw_bits(32, r);
            run_one(b, r[W-1:0] & r[2*W-1:W], a, r[3*W-1:2*W] & r[4*W-1:3*W], 1'b0);
        end

        // Tainted start strobe
        for (int i = 0; i < N_START_T; i++) begin
            draw_bits(32, r);
            run_one(r[W-1:0], r[2*W-1:W], r[3*W-1:2*W], '0, 1'b1);
            assert (product_t === {PW{1'b1}})
                else begin
                    taint_errs++;
                    $display("ERR %0t product_t got %h expected %h", $time, product_t,
                             {PW{1'b1}});
                end
        end

        // One tainted multiplier bit at each position
        for (int j = 0; j < W; j++) begin
            draw_bits(2 * W, r);
            run_one(r[W-1:0], W'(1) << j, r[2*W-1:W], '0, 1'b0);
        end

        repeat (4 * W) @(posedge clk);
        assert (done_count == accepted)
            else begin
                proto_errs++;
                $display("Saw %0d done pulses for %0d accepted starts", done_count, accepted);
            end
        $display("Errors: value %0d, taint %0d, protocol %0d", value_errs, taint_errs,
                 proto_errs);
        if (value_errs + taint_errs + proto_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+logic
logic/mul_taint_pkg.sv
logic/mul_control.sv
logic/multiplicand_reg.sv
logic/multiplier_reg.sv
logic/running_sum.sv
logic/mul_top.sv
testbench/mul_top_sva.sv
testbench/mul_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module mul_top_tb -o sim_mul
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_mul > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Verification failed" sim.log; then
    exit 1
fi
exit 0
